// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - files:
      - common/cache_pkg.sv
      - cache/cache_meta_array.sv
      - cache/cache_data_array.sv
      - cache/i_cache.sv
      - cache/d_cache.sv
      - source/cache_fill_ctrl.sv
      - source/cache_top.sv
  - target: test
    files:
      - verification/cache_tb.sv

// ==== cache/cache_data_array.sv ====
// **************************************
// one way, 64 sets x 8 words, async read
// contents undefined until first write
// **************************************
`timescale 1ns/1ps

module cache_data_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cache_pkg::set_idx_t  set,
  input  cache_pkg::word_idx_t word_idx,
  input  logic                 we,
  input  cache_pkg::word_t     wdata,
  output cache_pkg::word_t     rdata
);
  import cache_pkg::*;

  word_t mem_q [NUM_SETS*WORDS_PER_BLOCK];
  logic [$bits(set_idx_t)+$bits(word_idx_t)-1:0] addr;
  logic  rd_en_q;  // set once the way has seen a write

  assign addr = {set, word_idx};  // set-major, words of a block adjacent

  // word write at the clock edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem_q[addr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_q <= 1'b0;
    end else if (we) begin
      rd_en_q <= 1'b1;
    end
  end

  // zero until first fill, keeps x off the read mux
  assign rdata = rd_en_q ? mem_q[addr] : '0;

endmodule

// ==== cache/cache_meta_array.sv ====
// **************************************
// valid/tag store for 2 ways, 1 lru bit per set
// lru bit names the least recently used way
// install has priority over the lru update on a hit
// **************************************
`timescale 1ns/1ps

module cache_meta_array (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::set_idx_t set,
  input  cache_pkg::tag_t     tag,
  input  logic                access,      // request enabled
  input  logic                install,     // write tag into victim way
  output logic                hit,
  output logic                hit_way,     // 0 -> way0, 1 -> way1
  output logic                victim_way   // lru way of the set
);
  import cache_pkg::*;

  meta_entry_t         meta_q [NUM_SETS][NUM_WAYS];
  logic [NUM_SETS-1:0] lru_q;
  meta_entry_t         new_entry;
  logic                hit0;
  logic                hit1;

  // both ways compared in parallel
  assign hit0 = meta_q[set][0].valid && (meta_q[set][0].tag == tag);
  assign hit1 = meta_q[set][1].valid && (meta_q[set][1].tag == tag);

  assign hit        = hit0 | hit1;
  assign hit_way    = hit1;          // never both on a legal fill sequence
  assign victim_way = lru_q[set];

  assign new_entry.valid = 1'b1;
  assign new_entry.tag   = tag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        meta_q[s][0] <= '0;
        meta_q[s][1] <= '0;
      end
      lru_q <= '0;
    end else if (install) begin
      // fill complete, new block becomes mru
      meta_q[set][victim_way] <= new_entry;
      lru_q[set]              <= ~lru_q[set];
    end else if (access && hit) begin
      lru_q[set] <= ~hit_way;  // point away from the way just used
    end
  end

endmodule

// ==== cache/d_cache.sv ====
// **************************************
// write-through, no allocate on store miss
// every store pulses mem_wr in its own cycle
// stores are enabled for one cycle only
// **************************************
`timescale 1ns/1ps

module d_cache (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::cache_req_t req,
  input  cache_pkg::fill_t      fill,
  output cache_pkg::word_t      rdata,
  output logic                  miss,
  output logic                  mem_wr,
  output cache_pkg::addr_t      mem_addr_wr,
  output cache_pkg::word_t      mem_wdata
);
  import cache_pkg::*;

  tag_t      req_tag;
  set_idx_t  req_set;
  word_idx_t word_idx;
  logic      hit;
  logic      hit_way;
  logic      victim_way;
  logic      store_hit;
  logic      we0;
  logic      we1;
  word_t     wr_word;   // fill word or store data
  word_t     rdata0;
  word_t     rdata1;

  assign req_tag  = req.addr[15:10];
  assign req_set  = req.addr[9:4];
  assign word_idx = fill.load_data ? fill.word_idx : req.addr[3:1];

  assign store_hit = req.en & req.wr & hit;
  assign miss      = req.en & ~req.wr & ~hit;  // store misses never fill

  // a fill and a store hit never share a cycle
  assign wr_word = fill.load_data ? fill.data : req.wdata;
  assign we0 = (fill.load_data & ~victim_way) | (store_hit & ~hit_way);
  assign we1 = (fill.load_data & victim_way) | (store_hit & hit_way);

  assign rdata = (req.en & hit) ? (hit_way ? rdata1 : rdata0) : '0;

  // write-through port
  assign mem_wr      = req.en & req.wr;
  assign mem_addr_wr = req.addr;
  assign mem_wdata   = req.wdata;

  cache_meta_array u_meta (
    .clk        (clk),
    .rst_n      (rst_n),
    .set        (req_set),
    .tag        (req_tag),
    .access     (req.en),   // store hits also refresh lru
    .install    (fill.load_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  cache_data_array u_way0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .set      (req_set),
    .word_idx (word_idx),
    .we       (we0),
    .wdata    (wr_word),
    .rdata    (rdata0)
  );

  cache_data_array u_way1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .set      (req_set),
    .word_idx (word_idx),
    .we       (we1),
    .wdata    (wr_word),
    .rdata    (rdata1)
  );

endmodule

// ==== cache/i_cache.sv ====
// **************************************
// read-only cache, 2 ways, lru replacement
// request must stay stable while miss is high
// rdata is 0 unless the access hits
// **************************************
`timescale 1ns/1ps

module i_cache (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::cache_req_t req,
  input  cache_pkg::fill_t      fill,
  output cache_pkg::word_t      rdata,
  output logic                  miss
);
  import cache_pkg::*;

  tag_t      req_tag;
  set_idx_t  req_set;
  word_idx_t word_idx;
  logic      hit;
  logic      hit_way;
  logic      victim_way;
  logic      we0;
  logic      we1;
  word_t     rdata0;
  word_t     rdata1;

  assign req_tag = req.addr[15:10];
  assign req_set = req.addr[9:4];
  // fill supplies its own word index, set comes from the held request
  assign word_idx = fill.load_data ? fill.word_idx : req.addr[3:1];

  assign miss = req.en & ~hit;

  // fills go to the lru way
  assign we0 = fill.load_data & ~victim_way;
  assign we1 = fill.load_data & victim_way;

  assign rdata = (req.en & hit) ? (hit_way ? rdata1 : rdata0) : '0;

  cache_meta_array u_meta (
    .clk        (clk),
    .rst_n      (rst_n),
    .set        (req_set),
    .tag        (req_tag),
    .access     (req.en),
    .install    (fill.load_tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  cache_data_array u_way0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .set      (req_set),
    .word_idx (word_idx),
    .we       (we0),
    .wdata    (fill.data),
    .rdata    (rdata0)
  );

  cache_data_array u_way1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .set      (req_set),
    .word_idx (word_idx),
    .we       (we1),
    .wdata    (fill.data),
    .rdata    (rdata1)
  );

endmodule

// ==== common/cache_pkg.sv ====
// **************************************
// geometry is fixed, 2 ways x 64 sets x 8 words
// addresses are byte addresses, bit 0 ignored
// **************************************
package cache_pkg;

  localparam int NUM_SETS        = 64;
  localparam int WORDS_PER_BLOCK = 8;
  localparam int NUM_WAYS        = 2;  // ways are explicit instances

  typedef logic [15:0] addr_t;      // byte address
  typedef logic [15:0] word_t;      // data word
  typedef logic [5:0]  tag_t;       // addr[15:10]
  typedef logic [5:0]  set_idx_t;   // addr[9:4]
  typedef logic [2:0]  word_idx_t;  // addr[3:1]

  // valid in bit 6, tag below it
  typedef struct packed {
    logic valid;
    tag_t tag;
  } meta_entry_t;

  typedef struct packed {
    logic  en;     // access valid
    logic  wr;     // store, 0 for fetches
    addr_t addr;
    word_t wdata;
  } cache_req_t;

  typedef struct packed {
    logic      load_data;  // write one word
    logic      load_tag;   // install tag, flip lru
    word_idx_t word_idx;
    word_t     data;
  } fill_t;

endpackage

// ==== source/cache_fill_ctrl.sv ====
// **************************************
// one block fill at a time, d-cache first
// memory returns 8 words in order, any gaps
// mem_rd waits out a store cycle
// **************************************
`timescale 1ns/1ps

module cache_fill_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_miss,
  input  logic              d_miss,
  input  cache_pkg::addr_t  i_addr,
  input  cache_pkg::addr_t  d_addr,
  input  logic              store_busy,   // mem_wr owns mem_addr this cycle
  output logic              mem_rd,
  output cache_pkg::addr_t  mem_rd_addr,
  input  logic              mem_rvalid,
  input  cache_pkg::word_t  mem_rdata,
  output cache_pkg::fill_t  i_fill,
  output cache_pkg::fill_t  d_fill
);
  import cache_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, BURST} state_t;

  state_t    state_q;
  logic      target_q;   // 1 -> d-cache
  addr_t     base_q;     // block base address
  word_idx_t cnt_q;      // next word of the burst
  logic      last_word;
  fill_t     fill_w;

  assign last_word = (cnt_q == word_idx_t'(WORDS_PER_BLOCK-1));

  assign mem_rd      = (state_q == REQ) & ~store_busy;
  assign mem_rd_addr = base_q;

  // word goes to the cache in the cycle it arrives
  assign fill_w.load_data = (state_q == BURST) & mem_rvalid;
  assign fill_w.load_tag  = (state_q == BURST) & mem_rvalid & last_word;
  assign fill_w.word_idx  = cnt_q;
  assign fill_w.data      = mem_rdata;

  assign i_fill = target_q ? '0 : fill_w;
  assign d_fill = target_q ? fill_w : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      target_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (d_miss || i_miss) begin
            target_q <= d_miss;  // data side wins a tie
            state_q  <= REQ;
          end
        end
        REQ: begin
          if (mem_rd) state_q <= BURST;
        end
        BURST: begin
          if (mem_rvalid) begin
            cnt_q <= cnt_q + word_idx_t'(1);
            if (last_word) state_q <= IDLE;  // tag lands at this edge
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // base address captured on acceptance
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      base_q <= d_miss ? {d_addr[15:4], 4'b0} : {i_addr[15:4], 4'b0};
    end
  end

endmodule

// ==== source/cache_top.sv ====
// **************************************
// i and d caches sharing one memory port
// mem_addr is the store address while mem_wr
// **************************************
`timescale 1ns/1ps

module cache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::cache_req_t i_req,
  input  cache_pkg::cache_req_t d_req,
  output cache_pkg::word_t      i_rdata,
  output logic                  i_miss,
  output cache_pkg::word_t      d_rdata,
  output logic                  d_miss,
  output logic                  mem_rd,
  output logic                  mem_wr,
  output cache_pkg::addr_t      mem_addr,
  output cache_pkg::word_t      mem_wdata,
  input  logic                  mem_rvalid,
  input  cache_pkg::word_t      mem_rdata
);
  import cache_pkg::*;

  fill_t i_fill;
  fill_t d_fill;
  addr_t mem_addr_wr;   // from d-cache store path
  addr_t mem_rd_addr;   // from fill controller

  // never both in one cycle, fill ctrl holds off mem_rd during a store
  assign mem_addr = mem_wr ? mem_addr_wr : mem_rd_addr;

  i_cache u_i_cache (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (i_req),
    .fill  (i_fill),
    .rdata (i_rdata),
    .miss  (i_miss)
  );

  d_cache u_d_cache (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (d_req),
    .fill        (d_fill),
    .rdata       (d_rdata),
    .miss        (d_miss),
    .mem_wr      (mem_wr),
    .mem_addr_wr (mem_addr_wr),
    .mem_wdata   (mem_wdata)
  );

  cache_fill_ctrl u_fill_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_miss      (i_miss),
    .d_miss      (d_miss),
    .i_addr      (i_req.addr),
    .d_addr      (d_req.addr),
    .store_busy  (mem_wr),
    .mem_rd      (mem_rd),
    .mem_rd_addr (mem_rd_addr),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .i_fill      (i_fill),
    .d_fill      (d_fill)
  );

endmodule

// ==== verification/cache_tb.sv ====
// ****************************************
// cache_top testbench run from the project root
// accesses come from verification/cache_tests.txt
// word memory and lru model live here
// stops at the first mismatch
// ****************************************
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int MAX_TESTS  = 64;
  localparam int MISS_LIMIT = 200;  // cycles allowed per miss

  logic       clk;
  logic       rst_n;
  cache_req_t i_req;
  cache_req_t d_req;
  word_t      i_rdata;
  logic       i_miss;
  word_t      d_rdata;
  logic       d_miss;
  logic       mem_rd;
  logic       mem_wr;
  addr_t      mem_addr;
  word_t      mem_wdata;
  logic       mem_rvalid;
  word_t      mem_rdata;

  word_t       mem [0:32767];          // word memory indexed by addr[15:1]
  logic [43:0] tests [0:MAX_TESTS-1];  // port, op, addr, wdata, expect
  logic [31:0] rng_q = 32'd99457;
  int          rd_count;
  int          wr_count;
  addr_t       rd_addrs [$];           // every mem_rd address in order

  // tag and lru model per port with 0 for I and 1 for D
  tag_t tag_m [2][NUM_SETS][2];
  logic val_m [2][NUM_SETS][2];
  logic lru_m [2][NUM_SETS];           // names the lru way

  cache_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_req      (i_req),
    .d_req      (d_req),
    .i_rdata    (i_rdata),
    .i_miss     (i_miss),
    .d_rdata    (d_rdata),
    .d_miss     (d_miss),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %h expected %h",
                          $time, what, actual, expected));
    end
  endtask

  // way holding the tag or -1 when the block is not cached
  function automatic int find_way(input int p, input addr_t a);
    int s;
    s = int'(a[9:4]);
    for (int w = 0; w < 2; w++) begin
      if (val_m[p][s][w] && tag_m[p][s][w] == a[15:10]) return w;
    end
    return -1;
  endfunction

  // a hit points lru away from its way and a miss installs into the lru way
  task automatic touch_model(input int p, input addr_t a);
    int   s;
    int   w;
    logic v;
    s = int'(a[9:4]);
    w = find_way(p, a);
    if (w >= 0) begin
      lru_m[p][s] = (w == 0);
    end else begin
      v = lru_m[p][s];
      val_m[p][s][v] = 1'b1;
      tag_m[p][s][v] = a[15:10];
      lru_m[p][s]    = ~v;
    end
  endtask

  task automatic wait_misses_low(input logic watch_i, input logic watch_d);
    int cycles;
    cycles = 0;
    while ((watch_i && i_miss) || (watch_d && d_miss)) begin
      if (cycles == MISS_LIMIT) abort_run("a cache miss never cleared within 200 cycles");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_access(input logic [43:0] t);
    logic       is_d;
    logic       is_store;
    addr_t      a;
    word_t      wd;
    logic       exp_miss;
    int         rd_before;
    int         wr_before;
    cache_req_t req;
    is_d     = t[40];
    is_store = t[36];
    a        = t[35:20];
    wd       = t[19:4];
    exp_miss = t[0];
    check_equal(find_way(int'(is_d), a) < 0, exp_miss, "test data against lru model");
    rd_before = rd_count;
    wr_before = wr_count;
    req = {1'b1, is_store, a, wd};  // en, wr, addr, wdata
    @(posedge clk);
    #5;
    if (is_d) d_req = req;
    else i_req = req;
    @(negedge clk);
    if (is_store) begin
      check_equal(mem_wr, 1, "store strobe");
      check_equal(mem_addr, a, "store address");
      check_equal(mem_wdata, wd, "store data");
      check_equal(d_miss, 0, "store raised a fill miss");
      if (!exp_miss) touch_model(1, a);  // store miss leaves the cache alone
    end else begin
      check_equal(is_d ? d_miss : i_miss, exp_miss, "miss in first cycle");
      wait_misses_low(!is_d, is_d);
      check_equal(is_d ? d_rdata : i_rdata, mem[a[15:1]], "load data");
      check_equal(rd_count - rd_before, exp_miss, "mem_rd pulses for one load");
      if (exp_miss) check_equal(rd_addrs[rd_before], {a[15:4], 4'h0}, "burst base address");
      touch_model(int'(is_d), a);
    end
    @(posedge clk);
    #5;
    if (is_d) d_req = '0;
    else i_req = '0;
    if (is_store) begin
      @(negedge clk);
      check_equal(wr_count - wr_before, 1, "mem_wr pulses per store");
      check_equal(rd_count - rd_before, 0, "mem_rd during a store");
    end
  endtask

  // ti holds the I load and td the D load issued in the same cycle
  task automatic run_joint(input logic [43:0] ti, input logic [43:0] td);
    addr_t ia;
    addr_t da;
    int    rd_before;
    ia = ti[35:20];
    da = td[35:20];
    check_equal(find_way(0, ia) < 0, ti[0], "test data against lru model, I side");
    check_equal(find_way(1, da) < 0, td[0], "test data against lru model, D side");
    rd_before = rd_count;
    @(posedge clk);
    #5;
    i_req = {1'b1, 1'b0, ia, 16'h0000};
    d_req = {1'b1, 1'b0, da, 16'h0000};
    @(negedge clk);
    check_equal(i_miss, ti[0], "joint I miss in first cycle");
    check_equal(d_miss, td[0], "joint D miss in first cycle");
    wait_misses_low(1'b1, 1'b1);
    check_equal(i_rdata, mem[ia[15:1]], "joint I load data");
    check_equal(d_rdata, mem[da[15:1]], "joint D load data");
    check_equal(rd_count - rd_before, int'(ti[0]) + int'(td[0]), "mem_rd pulses for joint");
    if (td[0]) check_equal(rd_addrs[rd_before], {da[15:4], 4'h0}, "data cache served first");
    touch_model(0, ia);
    touch_model(1, da);
    @(posedge clk);
    #5;
    i_req = '0;
    d_req = '0;
  endtask

  // store strobes update the model and mem_rd pulses are logged
  always @(posedge clk) begin
    if (mem_wr) begin
      mem[mem_addr[15:1]] <= mem_wdata;
      wr_count <= wr_count + 1;
    end
    if (mem_rd) begin
      rd_count <= rd_count + 1;
      rd_addrs.push_back(mem_addr);
    end
  end

  // 8 words per mem_rd with 0..3 idle cycles before each
  initial begin : mem_responder
    addr_t base;
    int    gap;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    forever begin
      @(posedge clk);
      if (mem_rd === 1'b1) begin
        base = mem_addr;
        #5;
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
          rng_q = xorshift32(rng_q);
          gap   = int'(rng_q[1:0]);
          repeat (gap) begin
            mem_rvalid = 1'b0;
            @(posedge clk);
            #5;
          end
          mem_rvalid = 1'b1;
          mem_rdata  = mem[base[15:1] + k];
          @(posedge clk);
          #5;
        end
        mem_rvalid = 1'b0;
      end
    end
  end

  initial begin : main
    int n;
    rst_n    = 1'b0;
    i_req    = '0;
    d_req    = '0;
    rd_count = 0;
    wr_count = 0;
    for (int w = 0; w < 32768; w++) mem[w] = ~addr_t'(w << 1);  // inverse of byte address
    for (int p = 0; p < 2; p++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        val_m[p][s][0] = 1'b0;
        val_m[p][s][1] = 1'b0;
        lru_m[p][s]    = 1'b0;
      end
    end
    for (int k = 0; k < MAX_TESTS; k++) tests[k] = '1;  // port F ends the list
    $readmemh("verification/cache_tests.txt", tests);
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;
    n = 0;
    while (n < MAX_TESTS && tests[n][43:40] != 4'hF) begin
      if (tests[n][39:36] == 4'h2) begin
        run_joint(tests[n], tests[n+1]);
        n += 2;
      end else begin
        run_access(tests[n]);
        n++;
      end
    end
    check_equal(n > 0, 1, "test file holds accesses");
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== verification/cache_tests.txt ====
// columns: port (0 I, 1 D) _ op (0 load, 1 store, 2 load joint with next line) _ addr _ wdata _ expect (0 hit, 1 miss)
// a joint line is the I load, the line after it is the D load issued in the same cycle
// cold loads on each port
0_0_0012_0000_1
1_0_0426_0000_1
// other words of the filled blocks
0_0_001E_0000_0
0_0_0010_0000_0
1_0_0420_0000_0
1_0_042E_0000_0
// lru in d set 5, A 0850, B 0C50, C 1050
1_0_0852_0000_1
1_0_0C54_0000_1
1_0_0856_0000_0
1_0_105A_0000_1
1_0_0850_0000_0
1_0_0C50_0000_1
// store hit then reload
1_1_0424_BEEF_0
1_0_0424_0000_0
// store miss, no allocate
1_1_3A30_1234_1
1_0_3A30_0000_1
// misses on both ports in one cycle
0_2_2160_0000_1
1_0_3290_0000_1

// ==== verilog.f ====
common/cache_pkg.sv
cache/cache_meta_array.sv
cache/cache_data_array.sv
cache/i_cache.sv
cache/d_cache.sv
source/cache_fill_ctrl.sv
source/cache_top.sv
verification/cache_tb.sv
